// ==== Makefile ====
# Verilator flow for the gaussian blur project
# usage: make lint | make sim | make clean

VERILATOR ?= verilator
TB_TOP    ?= gaussian_blur_tb
RTL_TOP   ?= gaussian_blur
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= === FAIL ===
PASS_MSG  ?= === PASS ===

SIM_FLAGS  ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall

ALL_SRCS := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(filter source/%,$(ALL_SRCS))
SIM_BIN  := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(SIM_BIN): $(ALL_SRCS) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q -- "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q -- "$(PASS_MSG)" $(LOG); then \
	  echo "simulation ended early, see $(LOG)"; exit 1; \
	else \
	  echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/gaussian_blur_props.sv ====
`timescale 1ns/10ps

module gaussian_blur_props #(
  parameter int AW = 5                         // row address width
) (
  input logic          clk,
  input logic          rst_n,
  input logic          blur_we,
  input logic [AW-1:0] blur_addr,
  input logic          done,
  input logic          buffer_we,
  input logic          fill_zero,
  input logic          kernel_en
);

  logic [AW-1:0] prev_addr;                    // address of last write
  logic          prev_valid;                   // a write seen in this run

  // forget the last write once a run has finished
  always_ff @(posedge clk) begin
    if (!rst_n || done) begin
      prev_addr  <= '0;
      prev_valid <= 1'b0;
    end else if (blur_we) begin
      prev_addr  <= blur_addr;
      prev_valid <= 1'b1;
    end
  end

  a_no_write_while_done: assert property (@(posedge clk) disable iff (!rst_n)
    blur_we |-> !done)
    else $error("blur_we high while done is high");

  a_addr_step: assert property (@(posedge clk) disable iff (!rst_n)
    (blur_we && prev_valid) |-> (blur_addr == prev_addr + AW'(1)))
    else $error("blur_addr did not advance by one row");

  a_zero_needs_we: assert property (@(posedge clk) disable iff (!rst_n)
    fill_zero |-> buffer_we)
    else $error("fill_zero high without buffer_we");

  a_we_kernel_apart: assert property (@(posedge clk) disable iff (!rst_n)
    !(kernel_en && buffer_we))
    else $error("kernel_en and buffer_we high together");

endmodule

bind gaussian_blur gaussian_blur_props #(
  .AW        (AW)
) u_props (
  .clk       (clk),
  .rst_n     (rst_n),
  .blur_we   (blur_we),
  .blur_addr (blur_addr),
  .done      (done),
  .buffer_we (buffer_we),
  .fill_zero (fill_zero),
  .kernel_en (kernel_en)
);

// ==== sim/gaussian_blur_tb.sv ====
`timescale 1ns/10ps

module gaussian_blur_tb;

  import blur_pkg::*;

  localparam int          IMG_H       = 12;
  localparam int          AW          = $clog2(IMG_H) + 1;
  localparam int          NUM_TESTS   = 5;
  localparam int          CYCLE_LIMIT = NUM_TESTS * (3 * (IMG_H + 1) + 20);
  localparam logic [31:0] SEED        = 32'h1076_b778;

  typedef enum logic [1:0] {
    PAT_ZERO,                                  // all pixels 0
    PAT_FULL,                                  // all pixels 255
    PAT_IMPULSE,                               // single 255 at (5,7)
    PAT_RANDOM                                 // $urandom pixels
  } pat_e;

  typedef struct packed {
    int row;
    int col;
    int value;                                 // hand-computed result
  } probe_s;

  typedef struct packed {
    pat_e         kind;
    int           n_probes;
    probe_s [0:2] probes;
  } test_s;

  // impulse taps are 4, 2 and 1 times 255, plus 8, over 16
  test_s tests [NUM_TESTS] = '{
    '{PAT_ZERO,    3, '{'{0, 0, 0},   '{5, 7, 0},   '{11, 15, 0}}},
    '{PAT_FULL,    3, '{'{0, 0, 143}, '{0, 7, 191}, '{5, 7, 255}}},
    '{PAT_IMPULSE, 3, '{'{5, 7, 64},  '{4, 7, 32},  '{6, 8, 16}}},
    '{PAT_RANDOM,  0, '{'{0, 0, 0},   '{0, 0, 0},   '{0, 0, 0}}},
    '{PAT_RANDOM,  0, '{'{0, 0, 0},   '{0, 0, 0},   '{0, 0, 0}}}
  };

  logic          clk;
  logic          rst_n;
  logic          start;
  logic [AW-1:0] img_addr;
  row_u          img_dout = '0;                // image memory read data
  logic          blur_we;
  logic [AW-1:0] blur_addr;
  row_u          blur_din;
  logic          done;

  row_u img_mem   [IMG_H];                     // image memory model
  row_u blur_mem  [IMG_H];                     // captured blur rows
  int   write_cnt [IMG_H];                     // writes per row this run
  int   next_addr;                             // expected next write row
  int   value_errs;
  int   proto_errs;
  int   cycles = 0;

  tb_clock u_clock (
    .clk (clk)
  );

  gaussian_blur #(
    .IMG_H     (IMG_H)
  ) uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .img_addr  (img_addr),
    .img_dout  (img_dout),
    .blur_we   (blur_we),
    .blur_addr (blur_addr),
    .blur_din  (blur_din),
    .done      (done)
  );

  // one-cycle read with a nonzero fill past the last row
  always @(posedge clk) begin
    if (int'(img_addr) < IMG_H) begin
      img_dout <= img_mem[img_addr];
    end else begin
      for (int c = 0; c < IMG_W; c++) begin
        img_dout.pix[c] <= ~pix_t'(img_addr);  // never a zero row
      end
    end
  end

  // blur memory sampled mid-cycle
  always @(negedge clk) begin
    if (rst_n && blur_we) begin
      assert (int'(blur_addr) == next_addr) else begin
        proto_errs++;
        $display("ERROR %0t: write to row %0d, expected row %0d", $time, blur_addr, next_addr);
      end
      if (int'(blur_addr) < IMG_H) begin
        blur_mem[blur_addr]  = blur_din;
        write_cnt[blur_addr] = write_cnt[blur_addr] + 1;
      end
      next_addr++;
    end
  end

  // run limit
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: done not reached within %0d cycles", CYCLE_LIMIT);
      $display("=== FAIL ===");
      $finish;
    end
  end

  task automatic load_image(input pat_e kind);
    for (int r = 0; r < IMG_H; r++) begin
      for (int c = 0; c < IMG_W; c++) begin
        case (kind)
          PAT_ZERO:    img_mem[r].pix[c] = 8'd0;
          PAT_FULL:    img_mem[r].pix[c] = 8'd255;
          PAT_IMPULSE: img_mem[r].pix[c] = (r == 5 && c == 7) ? 8'd255 : 8'd0;
          default:     img_mem[r].pix[c] = pix_t'($urandom);
        endcase
      end
    end
  endtask

  // weights 1 2 1 / 2 4 2 / 1 2 1, zero outside the image
  function automatic int ref_pixel(input int r, input int c);
    int sum;
    int w;
    sum = 8;                                   // round to nearest
    for (int dr = -1; dr <= 1; dr++) begin
      for (int dc = -1; dc <= 1; dc++) begin
        w = (dr == 0 ? 2 : 1) * (dc == 0 ? 2 : 1);
        if (r + dr >= 0 && r + dr < IMG_H && c + dc >= 0 && c + dc < IMG_W) begin
          sum += w * int'(img_mem[r + dr].pix[c + dc]);
        end
      end
    end
    return sum / 16;
  endfunction

  task automatic run_test(input int t);
    test_s tc;
    int    got;
    tc = tests[t];
    load_image(tc.kind);                       // DUT idle here
    for (int r = 0; r < IMG_H; r++) begin
      write_cnt[r] = 0;
    end
    next_addr = 0;
    start     = 1'b1;
    @(negedge clk);
    start = 1'b0;
    assert (!done) else begin                  // done drops once start is taken
      proto_errs++;
      $display("ERROR %0t: test %0d done still high after start", $time, t);
    end
    while (!done) begin
      @(negedge clk);
    end
    for (int r = 0; r < IMG_H; r++) begin
      assert (write_cnt[r] == 1) else begin
        proto_errs++;
        $display("ERROR %0t: test %0d row %0d written %0d times", $time, t, r, write_cnt[r]);
      end
      for (int c = 0; c < IMG_W; c++) begin
        got = int'(blur_mem[r].pix[c]);
        assert (got == ref_pixel(r, c)) else begin
          value_errs++;
          $display("ERROR %0t: test %0d pixel (%0d,%0d) got %0d expected %0d",
                   $time, t, r, c, got, ref_pixel(r, c));
        end
      end
    end
    for (int p = 0; p < tc.n_probes; p++) begin
      got = int'(blur_mem[tc.probes[p].row].pix[tc.probes[p].col]);
      assert (got == tc.probes[p].value) else begin
        value_errs++;
        $display("ERROR %0t: test %0d probe (%0d,%0d) got %0d expected %0d", $time, t,
                 tc.probes[p].row, tc.probes[p].col, got, tc.probes[p].value);
      end
    end
  endtask

  initial begin
    void'($urandom(SEED));
    value_errs = 0;
    proto_errs = 0;
    next_addr  = 0;
    rst_n      = 1'b0;
    start      = 1'b0;
    for (int r = 0; r < IMG_H; r++) begin
      img_mem[r]   = '0;
      blur_mem[r]  = '0;
      write_cnt[r] = 0;
    end
    repeat (3) @(negedge clk);                 // reset over 3 rising edges
    rst_n = 1'b1;
    @(negedge clk);
    assert (!done && !blur_we && !uut.buffer_we) else begin
      proto_errs++;
      $display("ERROR %0t: done, blur_we or buffer_we high after reset", $time);
    end
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);                             // each run restarts after done
    end
    $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock #(
  parameter realtime PERIOD = 8.0              // ns
) (
  output logic clk
);

  initial begin
    clk = 1'b0;                                // first edge is a rising one
    forever begin
      #(PERIOD / 2.0) clk = ~clk;
    end
  end

endmodule

// ==== source/blur_ctrl.sv ====
`timescale 1ns/10ps

module blur_ctrl #(
  parameter  int IMG_H = 12,                   // image rows
  localparam int AW    = $clog2(IMG_H) + 1     // row address width
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          start,                 // one-cycle request
  output logic [AW-1:0] img_addr,              // image row to read
  output logic          buffer_we,             // shift line buffer
  output logic          fill_zero,             // shift in zero row
  output logic          clear,                 // wipe line buffer
  output logic          kernel_en,             // capture blurred row
  output logic          blur_we,               // blur memory write
  output logic [AW-1:0] blur_addr,             // blur memory row
  output logic          done                   // whole image written
);

  // three cycles per row step
  typedef enum logic [1:0] {
    PH_A,                                      // row address out
    PH_B,                                      // row data back
    PH_C                                       // kernel capture
  } phase_e;

  localparam logic [AW-1:0] LAST_STEP = AW'(IMG_H);      // zero-row step
  localparam logic [AW-1:0] LAST_ROW  = AW'(IMG_H - 1);  // last output row

  logic          busy_q;                       // running row steps
  phase_e        phase_q;                      // cycle within step
  logic [AW-1:0] step_q;                       // step k, 0..IMG_H
  logic          start_ok;                     // start taken this cycle
  logic          step_end;                     // last cycle of a step
  logic          last_step;                    // step IMG_H

  // idle means no steps and no write still pending
  assign start_ok  = start && !busy_q && !blur_we;
  assign step_end  = busy_q && (phase_q == PH_C);
  assign last_step = (step_q == LAST_STEP);

  // run flag
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
    end else if (start_ok) begin
      busy_q <= 1'b1;
    end else if (step_end && last_step) begin
      busy_q <= 1'b0;                          // after last C
    end
  end

  // phase rotates A B C while busy
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase_q <= PH_A;
    end else if (start_ok) begin
      phase_q <= PH_A;
    end else if (busy_q) begin
      case (phase_q)
        PH_A:    phase_q <= PH_B;
        PH_B:    phase_q <= PH_C;
        default: phase_q <= PH_A;              // C wraps to next step
      endcase
    end
  end

  // step counter doubles as image row address
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      step_q <= '0;
    end else if (start_ok) begin
      step_q <= '0;
    end else if (step_end && !last_step) begin
      step_q <= step_q + AW'(1);
    end
  end

  assign img_addr  = step_q;                   // valid in phase A
  assign buffer_we = busy_q && (phase_q == PH_B);
  assign fill_zero = buffer_we && last_step;   // bottom border row
  assign kernel_en = step_end && (step_q != '0);  // window full from step 1
  assign clear     = start_ok;                 // row 0 sees zeros above

  // write one cycle after the kernel captures
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      blur_we   <= 1'b0;
      blur_addr <= '0;
    end else begin
      blur_we <= kernel_en;
      if (kernel_en) begin
        blur_addr <= step_q - AW'(1);          // output lags one row
      end
    end
  end

  // done after last write, held until next start
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done <= 1'b0;
    end else if (start_ok) begin
      done <= 1'b0;
    end else if (blur_we && (blur_addr == LAST_ROW)) begin
      done <= 1'b1;
    end
  end

endmodule

// ==== source/blur_pkg.sv ====
package blur_pkg;

  // pixel and row geometry
  localparam int PIX_W = 8;                    // bits per pixel
  localparam int IMG_W = 16;                   // pixels per row
  localparam int ROW_W = IMG_W * PIX_W;        // one memory word per row

  // accumulator holds 16 * 255 plus rounding
  localparam int ACC_W = 12;

  typedef logic [PIX_W-1:0] pix_t;             // unsigned pixel

  // one image row
  // memories see a flat word and the kernel sees pixels
  typedef union packed {
    logic [ROW_W-1:0]      flat;               // memory port view
    pix_t [IMG_W-1:0]      pix;                // pixel 0 in low bits
  } row_u;

  // three-row window from the line buffer
  typedef struct packed {
    row_u top;                                 // row above
    row_u mid;                                 // row being blurred
    row_u bot;                                 // row below
  } window_s;

  // 3x3 gaussian weights 1 2 1 / 2 4 2 / 1 2 1
  localparam logic [ACC_W-1:0] K_CORNER = ACC_W'(1);   // diagonals
  localparam logic [ACC_W-1:0] K_EDGE   = ACC_W'(2);   // n s e w
  localparam logic [ACC_W-1:0] K_CENTER = ACC_W'(4);   // centre tap

  // weights sum to 16
  localparam logic [ACC_W-1:0] K_ROUND  = ACC_W'(8);   // half of 16
  localparam int               K_SHIFT  = 4;           // divide by 16

endpackage

// ==== source/blur_row_3x3.sv ====
`timescale 1ns/10ps

module blur_row_3x3 (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              kernel_en,         // capture this window
  input  blur_pkg::window_s window,            // rows above, centre, below
  output blur_pkg::row_u    blur_din           // blurred centre row
);

  import blur_pkg::*;

  localparam int CW = $clog2(IMG_W);           // column index width

  logic [ACC_W-1:0] corner_sum [IMG_W];        // four diagonal taps
  logic [ACC_W-1:0] edge_sum   [IMG_W];        // four side taps
  logic [ACC_W-1:0] acc        [IMG_W];        // weighted sum plus round
  row_u             blur_next;                 // row before register

  // pixel at column c, zero outside the row
  function automatic logic [ACC_W-1:0] tap(input row_u r, input int c);
    if (c < 0 || c >= IMG_W) begin
      return '0;                               // left or right border
    end
    return ACC_W'(r.pix[CW'(c)]);
  endfunction

  // whole row in parallel
  always_comb begin
    for (int c = 0; c < IMG_W; c++) begin
      corner_sum[c] = tap(window.top, c - 1) + tap(window.top, c + 1)
                    + tap(window.bot, c - 1) + tap(window.bot, c + 1);
      edge_sum[c]   = tap(window.top, c) + tap(window.bot, c)
                    + tap(window.mid, c - 1) + tap(window.mid, c + 1);
      acc[c]        = K_CORNER * corner_sum[c]
                    + K_EDGE * edge_sum[c]
                    + K_CENTER * tap(window.mid, c)
                    + K_ROUND;                 // max 4088 fits ACC_W
      blur_next.pix[c] = acc[c][K_SHIFT +: PIX_W];  // divide by 16
    end
  end

  // result held until the next capture
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      blur_din <= '0;
    end else if (kernel_en) begin
      blur_din <= blur_next;
    end
  end

endmodule

// ==== source/gaussian_blur.sv ====
`timescale 1ns/10ps

module gaussian_blur #(
  parameter  int IMG_H = 12,                   // image rows
  localparam int AW    = $clog2(IMG_H) + 1     // row address width
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           start,                // accepted while idle
  output logic [AW-1:0]  img_addr,             // image memory row address
  input  blur_pkg::row_u img_dout,             // one cycle after img_addr
  output logic           blur_we,              // one pulse per output row
  output logic [AW-1:0]  blur_addr,            // output row address
  output blur_pkg::row_u blur_din,             // blurred row
  output logic           done                  // level until next start
);

  import blur_pkg::*;

  logic    buffer_we;                          // line buffer shift
  logic    fill_zero;                          // zero row after last row
  logic    clear;                              // wipe buffer on start
  logic    kernel_en;                          // kernel capture
  window_s window;                             // three rows to kernel

  blur_ctrl #(
    .IMG_H     (IMG_H)
  ) u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .img_addr  (img_addr),
    .buffer_we (buffer_we),
    .fill_zero (fill_zero),
    .clear     (clear),
    .kernel_en (kernel_en),
    .blur_we   (blur_we),
    .blur_addr (blur_addr),
    .done      (done)
  );

  line_buffer u_line_buffer (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (clear),
    .buffer_we (buffer_we),
    .fill_zero (fill_zero),
    .img_dout  (img_dout),
    .window    (window)
  );

  blur_row_3x3 u_kernel (
    .clk       (clk),
    .rst_n     (rst_n),
    .kernel_en (kernel_en),
    .window    (window),
    .blur_din  (blur_din)
  );

endmodule

// ==== source/line_buffer.sv ====
`timescale 1ns/10ps

module line_buffer (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              clear,             // start of a new image
  input  logic              buffer_we,         // shift one row
  input  logic              fill_zero,         // load zero instead of data
  input  blur_pkg::row_u    img_dout,          // row from image memory
  output blur_pkg::window_s window             // three rows to kernel
);

  import blur_pkg::*;

  row_u top_q;                                 // oldest row
  row_u mid_q;                                 // centre row
  row_u bot_q;                                 // newest row
  row_u in_row;                                // row entering bottom

  // bottom border past the last image row
  assign in_row = fill_zero ? row_u'('0) : img_dout;

  // shift upward on every write
  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      top_q <= '0;                             // top border for row 0
      mid_q <= '0;
      bot_q <= '0;
    end else if (buffer_we) begin
      top_q <= mid_q;
      mid_q <= bot_q;
      bot_q <= in_row;
    end
  end

  assign window.top = top_q;
  assign window.mid = mid_q;
  assign window.bot = bot_q;

endmodule

// ==== src.f ====
source/blur_pkg.sv
source/blur_ctrl.sv
source/line_buffer.sv
source/blur_row_3x3.sv
source/gaussian_blur.sv
sim/tb_clock.sv
sim/gaussian_blur_props.sv
sim/gaussian_blur_tb.sv
